//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_calc_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ascii_alu.sv
module ascii_alu (
    input  calc_pkg::digits_t a,
    input  calc_pkg::digits_t b,
    input  calc_pkg::op_e     op,
    output calc_pkg::digits_t result
);

    localparam int RW = calc_pkg::RESULT_W;

    logic [RW-1:0] bin_a;
    logic [RW-1:0] bin_b;
    logic [RW-1:0] bin_r;
    logic [RW-1:0] low_two;  // result mod 100
    logic [RW-1:0] r_tens;
    logic [RW-1:0] r_units;

    function automatic logic [RW-1:0] to_bin(input calc_pkg::digits_t d);
        logic [RW-1:0] t;
        logic [RW-1:0] u;
        t = RW'(d.tens - calc_pkg::ASCII_ZERO);
        u = RW'(d.units - calc_pkg::ASCII_ZERO);
        return t * RW'(10) + u;
    endfunction

    always_comb begin
        bin_a = to_bin(a);
        bin_b = to_bin(b);
        case (op)
            calc_pkg::OP_ADD: bin_r = bin_a + bin_b;
            calc_pkg::OP_SUB: bin_r = bin_a - bin_b;  // wraps below zero
            calc_pkg::OP_MUL: bin_r = bin_a * bin_b;
            calc_pkg::OP_DIV: bin_r = (bin_b != '0) ? bin_a / bin_b : '0;
            default:          bin_r = '0;
        endcase
        low_two = bin_r % RW'(100);
        r_tens  = low_two / RW'(10);
        r_units = low_two % RW'(10);
        result.tens  = calc_pkg::ASCII_ZERO + calc_pkg::DATA_W'(r_tens);
        result.units = calc_pkg::ASCII_ZERO + calc_pkg::DATA_W'(r_units);
    end

endmodule

//--- calc_fsm.sv
module calc_fsm (
    input  logic              clk,
    input  logic              rstn,
    input  logic              rx_valid,
    input  calc_pkg::ascii_t  rx_data,
    output calc_pkg::digits_t shown
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_BUF_1,
        S_UNITS_1,
        S_OPERATOR,
        S_TENS_2,
        S_BUF_2,
        S_UNITS_2,
        S_CALC,
        S_CALC_2
    } calc_state_e;

    // tens '0' and units blank
    localparam calc_pkg::digits_t SHOWN_INIT = '{tens: calc_pkg::ASCII_ZERO, units: '0};
    localparam calc_pkg::digits_t ZERO_PAIR  = '{
        tens:  calc_pkg::ASCII_ZERO,
        units: calc_pkg::ASCII_ZERO
    };

    calc_state_e       state;
    calc_pkg::digits_t acc;       // first operand, then running result
    calc_pkg::digits_t opnd;      // second operand
    calc_pkg::op_e     op_q;
    calc_pkg::digits_t calc_res;
    logic              is_digit;
    logic              is_op;
    calc_pkg::op_e     key_op;

    ascii_alu i_alu (
        .a      (acc),
        .b      (opnd),
        .op     (op_q),
        .result (calc_res)
    );

    always_comb begin
        is_digit = (rx_data >= calc_pkg::ASCII_ZERO) && (rx_data <= calc_pkg::ASCII_NINE);
        is_op    = 1'b1;
        key_op   = calc_pkg::OP_ADD;
        case (rx_data)
            calc_pkg::ASCII_PLUS:  key_op = calc_pkg::OP_ADD;
            calc_pkg::ASCII_MINUS: key_op = calc_pkg::OP_SUB;
            calc_pkg::ASCII_STAR:  key_op = calc_pkg::OP_MUL;
            calc_pkg::ASCII_SLASH: key_op = calc_pkg::OP_DIV;
            default:               is_op  = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            acc   <= ZERO_PAIR;
            opnd  <= ZERO_PAIR;
            op_q  <= calc_pkg::OP_ADD;
            shown <= SHOWN_INIT;
        end else if (rx_valid && rx_data == calc_pkg::ASCII_CLEAR) begin
            state <= S_IDLE;  // clear from any state
            acc   <= ZERO_PAIR;
            opnd  <= ZERO_PAIR;
            op_q  <= calc_pkg::OP_ADD;
            shown <= SHOWN_INIT;
        end else if (state == S_CALC_2) begin
            // alu output valid now that operand tens is '0'
            shown <= calc_res;
            acc   <= calc_res;
            state <= S_OPERATOR;
        end else if (rx_valid) begin
            case (state)
                S_IDLE: if (is_digit) begin
                    acc   <= '{tens: rx_data, units: rx_data};
                    state <= S_BUF_1;
                end
                S_BUF_1: if (rx_data == calc_pkg::ASCII_SPACE) begin
                    state <= S_UNITS_1;
                end
                S_UNITS_1: begin
                    if (is_digit) begin
                        acc.units <= rx_data;
                        shown     <= '{tens: acc.tens, units: rx_data};
                        state     <= S_OPERATOR;
                    end else if (is_op) begin  // single-digit first operand
                        op_q     <= key_op;
                        acc.tens <= calc_pkg::ASCII_ZERO;
                        shown    <= '{tens: calc_pkg::ASCII_ZERO, units: acc.units};
                        state    <= S_TENS_2;
                    end
                end
                S_OPERATOR: if (is_op) begin
                    op_q  <= key_op;
                    state <= S_TENS_2;
                end
                S_TENS_2: if (is_digit) begin
                    opnd  <= '{tens: rx_data, units: rx_data};
                    state <= S_BUF_2;
                end
                S_BUF_2: if (rx_data == calc_pkg::ASCII_SPACE) begin
                    state <= S_UNITS_2;
                end
                S_UNITS_2: begin
                    if (is_digit) begin
                        opnd.units <= rx_data;
                        shown      <= '{tens: opnd.tens, units: rx_data};
                        state      <= S_CALC;
                    end else if (rx_data == calc_pkg::ASCII_EQUAL) begin
                        opnd.tens <= calc_pkg::ASCII_ZERO;
                        shown     <= '{tens: calc_pkg::ASCII_ZERO, units: opnd.units};
                        state     <= S_CALC_2;
                    end
                end
                S_CALC: if (rx_data == calc_pkg::ASCII_EQUAL) begin
                    shown <= calc_res;
                    acc   <= calc_res;  // result chains into next expression
                    state <= S_OPERATOR;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- calc_pkg.sv
package calc_pkg;

    localparam int DATA_W   = 8;   // uart byte and ascii char
    localparam int RESULT_W = 14;  // binary result, wraps mod 16384

    typedef logic [DATA_W-1:0] ascii_t;

    // keys recognized by the parser and the arithmetic unit
    localparam ascii_t ASCII_ZERO  = 8'h30;
    localparam ascii_t ASCII_NINE  = 8'h39;
    localparam ascii_t ASCII_SPACE = 8'h20;  // separates tens and units
    localparam ascii_t ASCII_EQUAL = 8'h3d;
    localparam ascii_t ASCII_CLEAR = 8'h63;  // 'c'
    localparam ascii_t ASCII_PLUS  = 8'h2b;
    localparam ascii_t ASCII_MINUS = 8'h2d;
    localparam ascii_t ASCII_STAR  = 8'h2a;
    localparam ascii_t ASCII_SLASH = 8'h2f;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_DIV
    } op_e;

    // a displayed pair of digits, tens in the upper byte
    typedef struct packed {
        ascii_t tens;
        ascii_t units;
    } digits_t;

endpackage

//--- calc_top.sv
module calc_top #(
    parameter int CLKS_PER_BIT    = 5208,
    parameter int DEBOUNCE_CYCLES = 50000
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             rxd,
    input  logic             key,
    output logic             txd,
    output calc_pkg::ascii_t digit_tens,
    output calc_pkg::ascii_t digit_units
);

    logic              rx_valid;
    calc_pkg::ascii_t  rx_data;
    calc_pkg::digits_t shown;
    logic              send_req;
    logic              send_ack;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx (
        .clk      (clk),
        .rstn     (rstn),
        .rxd      (rxd),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    calc_fsm i_calc_fsm (
        .clk      (clk),
        .rstn     (rstn),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .shown    (shown)
    );

    key_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_key_debounce (
        .clk      (clk),
        .rstn     (rstn),
        .key      (key),
        .send_ack (send_ack),
        .send_req (send_req)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_tx (
        .clk      (clk),
        .rstn     (rstn),
        .send_req (send_req),
        .shown    (shown),
        .txd      (txd),
        .send_ack (send_ack)
    );

    assign digit_tens  = shown.tens;
    assign digit_units = shown.units;

endmodule

//--- key_debounce.sv
module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 50000
) (
    input  logic clk,
    input  logic rstn,
    input  logic key,
    input  logic send_ack,
    output logic send_req
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [1:0]       key_sync;
    logic             key_s;
    logic             level;     // debounced key
    logic [CNT_W-1:0] cnt;
    logic             settle;    // new level held long enough
    logic             press;

    assign key_s  = key_sync[1];
    assign settle = (key_s != level) && (cnt == CNT_END);
    assign press  = settle && key_s;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            key_sync <= 2'b00;
            level    <= 1'b0;
            cnt      <= '0;
            send_req <= 1'b0;
        end else begin
            key_sync <= {key_sync[0], key};
            if (key_s == level || settle)
                cnt <= '0;  // any bounce restarts the count
            else
                cnt <= cnt + 1'b1;
            if (settle)
                level <= key_s;
            if (send_ack)
                send_req <= 1'b0;
            else if (press)
                send_req <= 1'b1;  // ignored while a request is outstanding
        end
    end

endmodule

//--- tb_calc_top.sv
module tb_calc_top;

    localparam int CLKS_PER_BIT    = 16;
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int RW              = calc_pkg::RESULT_W;
    localparam int WAIT_LIMIT      = 4000;    // two frames plus debounce, with margin
    localparam logic [23:0] OP_KEYS = "+*-";
    localparam calc_pkg::digits_t INIT_PAIR = '{tens: calc_pkg::ASCII_ZERO, units: 8'h00};

    logic              clk;
    logic              rstn;
    logic              rxd;
    logic              key;
    logic              txd;
    calc_pkg::ascii_t  digit_tens;
    calc_pkg::ascii_t  digit_units;
    calc_pkg::digits_t exp_pair;
    logic              exp_strobe;
    int                frames_exp;
    int                frames_seen;
    int                check_errors;
    int                timeouts;
    int                seed;
    int                a;
    int                b;
    int                i;

    calc_top #(
        .CLKS_PER_BIT    (CLKS_PER_BIT),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .rxd         (rxd),
        .key         (key),
        .txd         (txd),
        .digit_tens  (digit_tens),
        .digit_units (digit_units)
    );

    tb_checker #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_checker (
        .clk         (clk),
        .rstn        (rstn),
        .txd         (txd),
        .digit_tens  (digit_tens),
        .digit_units (digit_units),
        .exp_pair    (exp_pair),
        .exp_strobe  (exp_strobe),
        .frames_exp  (frames_exp),
        .frames_seen (frames_seen),
        .errors      (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic calc_pkg::digits_t calc_ref(input int x, input int y, input byte op);
        logic [RW-1:0]     r;
        int                low;
        calc_pkg::digits_t d;
        case (op)
            "+":     r = RW'(x + y);
            "-":     r = RW'(x - y);  // negative wraps in RW bits
            "*":     r = RW'(x * y);
            default: r = (y == 0) ? '0 : RW'(x / y);
        endcase
        low     = int'(r) % 100;
        d.tens  = calc_pkg::ASCII_ZERO + 8'(low / 10);
        d.units = calc_pkg::ASCII_ZERO + 8'(low % 10);
        return d;
    endfunction

    function automatic int pair_value(input calc_pkg::digits_t d);
        return int'(d.tens - calc_pkg::ASCII_ZERO) * 10 + int'(d.units - calc_pkg::ASCII_ZERO);
    endfunction

    task automatic send_byte(input calc_pkg::ascii_t data);
        int k;
        @(negedge clk);
        rxd = 1'b0;  // start bit
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (k = 0; k < 8; k++) begin
            rxd = data[k];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rxd = 1'b1;  // stop bit
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_text(input string s);
        int k;
        for (k = 0; k < s.len(); k++)
            send_byte(s[k]);
    endtask

    task automatic expect_pair(input calc_pkg::digits_t pair);
        @(negedge clk);
        exp_pair   = pair;
        exp_strobe = 1'b1;
        @(negedge clk);
        exp_strobe = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic two_digit_expr(input int x, input int y, input byte op);
        send_text($sformatf("c%0d %0d%c%0d %0d=", x / 10, x % 10, op, y / 10, y % 10));
        expect_pair(calc_ref(x, y, op));
    endtask

    task automatic one_digit_expr(input int x, input int y, input byte op);
        send_text($sformatf("c%0d %0d%c%0d =", x / 10, x % 10, op, y));
        expect_pair(calc_ref(x, y, op));
    endtask

    // previous result is the first operand
    task automatic chain_expr(input int y, input byte op);
        calc_pkg::digits_t want;
        want = calc_ref(pair_value(exp_pair), y, op);
        send_text($sformatf("%c%0d %0d=", op, y / 10, y % 10));
        expect_pair(want);
    endtask

    task automatic press_key();
        @(negedge clk);
        key = 1'b1;
        repeat (40) @(negedge clk);
        key = 1'b0;
    endtask

    task automatic wait_frames(input int target);
        int n;
        n = 0;
        while (frames_seen < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (frames_seen < target) begin
            $display("timeout: %0d of %0d frames seen on txd", frames_seen, target);
            timeouts++;
        end
    endtask

    task automatic button_send(input bit twice);
        frames_exp = frames_exp + 2;
        press_key();
        if (twice) begin
            repeat (20) @(negedge clk);
            press_key();  // lands while the tens frame is going out
        end
        wait_frames(frames_exp);
        repeat (CLKS_PER_BIT * 24) @(negedge clk);  // window for a stray frame
    endtask

    initial begin
        rstn       = 1'b0;
        rxd        = 1'b1;
        key        = 1'b0;
        exp_pair   = INIT_PAIR;
        exp_strobe = 1'b0;
        frames_exp = 0;
        timeouts   = 0;
        seed       = 32'h1aeb_c54a;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        repeat (4) @(negedge clk);
        expect_pair(INIT_PAIR);

        two_digit_expr(15, 47, "-");
        for (i = 0; i < 9; i++) begin
            a = {$random(seed)} % 100;
            b = {$random(seed)} % 100;
            two_digit_expr(a, b, OP_KEYS[8*(i % 3) +: 8]);
        end

        for (i = 0; i < 4; i++) begin
            a = {$random(seed)} % 100;
            b = 1 + {$random(seed)} % 9;
            one_digit_expr(a, b, "/");
        end
        one_digit_expr(37, 0, "/");  // divide by zero
        one_digit_expr(58, 6, "+");

        chain_expr(12, "*");
        chain_expr(99, "-");
        button_send(1'b1);

        send_text("c4 7+1c");
        expect_pair(INIT_PAIR);
        button_send(1'b0);

        repeat (20) @(negedge clk);
        $display("errors: %0d check failures, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tb_checker.sv
module tb_checker #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              txd,
    input  calc_pkg::ascii_t  digit_tens,
    input  calc_pkg::ascii_t  digit_units,
    input  calc_pkg::digits_t exp_pair,
    input  logic              exp_strobe,
    input  int                frames_exp,
    output int                frames_seen,
    output int                errors
);

    localparam int SETTLE_LIMIT = 5;  // cycles for the display to catch up

    task automatic report(input string name, input logic [7:0] want, input logic [7:0] got);
        $display("CHECK FAILED t=%0t signal=%s expected=%h actual=%h", $time, name, want, got);
        errors++;
    endtask

    initial begin : reset_check
        int n;
        errors      = 0;
        frames_seen = 0;
        n           = 0;
        while (rstn !== 1'b1 && n < 1000) begin
            @(posedge clk);
            n++;
        end
        if (rstn !== 1'b1) begin
            $display("reset was not released within %0d cycles", n);
            errors++;
        end else if (txd !== 1'b1) begin
            report("txd", 8'h01, {7'b0, txd});  // line must idle high
        end
    end

    initial begin : digit_check
        int n;
        forever begin
            @(posedge clk);
            if (exp_strobe === 1'b1) begin
                n = 0;
                while ({digit_tens, digit_units} !== exp_pair && n < SETTLE_LIMIT) begin
                    @(posedge clk);
                    n++;
                end
                if (digit_tens !== exp_pair.tens)
                    report("digit_tens", exp_pair.tens, digit_tens);
                if (digit_units !== exp_pair.units)
                    report("digit_units", exp_pair.units, digit_units);
            end
        end
    end

    // decodes every frame on txd, tens and units alternate
    initial begin : frame_decode
        calc_pkg::ascii_t  rx_byte;
        calc_pkg::ascii_t  want;
        calc_pkg::digits_t tx_pair;
        int                k;
        tx_pair = '0;
        forever begin
            @(posedge clk);
            if (rstn === 1'b1 && txd === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(posedge clk);  // middle of start bit
                for (k = 0; k < calc_pkg::DATA_W; k++) begin
                    repeat (CLKS_PER_BIT) @(posedge clk);
                    rx_byte[k] = txd;  // lsb first
                end
                repeat (CLKS_PER_BIT) @(posedge clk);
                if (txd !== 1'b1) begin
                    $display("framing error on txd at %0t, stop bit is not high", $time);
                    errors++;
                end
                if (frames_seen >= frames_exp) begin
                    $display("unexpected extra frame on txd at %0t", $time);
                    errors++;
                end
                if (frames_seen % 2 == 0)
                    tx_pair = exp_pair;  // pair on display when sending starts
                want = (frames_seen % 2 == 0) ? tx_pair.tens : tx_pair.units;
                if (rx_byte !== want)
                    report("txd", want, rx_byte);
                frames_seen++;
            end
        end
    end

endmodule

//--- uart_rx.sv
module uart_rx #(
    parameter int CLKS_PER_BIT = 5208
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             rxd,
    output logic             rx_valid,
    output calc_pkg::ascii_t rx_data
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] FULL_END = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [1:0]       rxd_sync;
    logic             rxd_s;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             bit_end;
    calc_pkg::ascii_t shift_q;

    assign rxd_s   = rxd_sync[1];
    assign bit_end = (cnt == FULL_END);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rxd_sync <= 2'b11;  // line idles high
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rxd_s)
                        state <= RX_START;
                end
                RX_START: begin
                    if (cnt == HALF_END) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? RX_IDLE : RX_DATA;  // glitch, not a start bit
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cnt      <= '0;
                        state    <= RX_IDLE;
                        rx_valid <= rxd_s;  // framing error drops the byte
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end)
            shift_q <= {rxd_s, shift_q[calc_pkg::DATA_W-1:1]};  // lsb first
        if (state == RX_STOP && bit_end && rxd_s)
            rx_data <= shift_q;
    end

endmodule

//--- uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 5208
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              send_req,
    input  calc_pkg::digits_t shown,
    output logic              txd,
    output logic              send_ack
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] FULL_END = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP,
        TX_NEXT,
        TX_ACK
    } tx_state_e;

    tx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             bit_end;
    logic             second;   // units frame in flight
    calc_pkg::ascii_t shift_q;
    calc_pkg::ascii_t units_q;

    assign bit_end = (cnt == FULL_END);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= TX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            second   <= 1'b0;
            send_ack <= 1'b0;
            txd      <= 1'b1;
        end else begin
            // line level follows the state one cycle later
            if (state == TX_START)
                txd <= 1'b0;
            else if (state == TX_DATA)
                txd <= shift_q[0];
            else
                txd <= 1'b1;

            case (state)
                TX_IDLE: begin
                    cnt    <= '0;
                    second <= 1'b0;
                    if (send_req)
                        state <= TX_START;
                end
                TX_START: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= TX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= second ? TX_ACK : TX_NEXT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_NEXT: begin
                    second <= 1'b1;
                    state  <= TX_START;
                end
                TX_ACK: begin
                    if (!send_ack) begin
                        send_ack <= 1'b1;
                    end else if (!send_req) begin  // requester has let go
                        send_ack <= 1'b0;
                        state    <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && send_req) begin
            shift_q <= shown.tens;   // tens goes out first
            units_q <= shown.units;
        end else if (state == TX_NEXT) begin
            shift_q <= units_q;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[calc_pkg::DATA_W-1:1]};
        end
    end

endmodule

//--- vlog.f
calc_pkg.sv
uart_rx.sv
uart_tx.sv
ascii_alu.sv
calc_fsm.sv
key_debounce.sv
calc_top.sv
tb_checker.sv
tb_calc_top.sv
